// File: hdl/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// Geometry of the instruction cache.
// Widths below must stay consistent with each other.

// Byte address width seen by the fetch stage.
`define ICACHE_ADDR_W 32

// Number of sets per way.
`define ICACHE_SETS 16

// Number of ways with one bit per way in a way mask.
`define ICACHE_WAYS 4

// Line size in bytes for four instruction words.
`define ICACHE_LINE_BYTES 16

// log2 of the set count.
`define ICACHE_INDEX_W 4

// log2 of the line size.
`define ICACHE_OFFSET_W 4

`endif

// File: hdl/icache_types_pkg.sv
`include "icache_cfg.svh"

package icache_types_pkg;

	// Byte address from the fetch stage.
	typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

	// Address bits above index and offset.
	typedef logic [`ICACHE_ADDR_W-`ICACHE_INDEX_W-`ICACHE_OFFSET_W-1:0] tag_t;

	typedef logic [`ICACHE_INDEX_W-1:0] index_t; // Set select.

	typedef logic [`ICACHE_OFFSET_W-1:0] offset_t; // Byte within a line.

	// Whole cache line, word 0 in the low bits.
	typedef logic [`ICACHE_LINE_BYTES*8-1:0] line_t;

	typedef logic [31:0] word_t; // One instruction.

	// One-hot way select that is all zero when no way applies.
	typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

endpackage

// File: hdl/icache_pipe_pkg.sv
package icache_pipe_pkg;

	// Fetch request as presented by the core.
	typedef struct packed {
		logic                    valid; // Request present.
		icache_types_pkg::addr_t addr;  // Byte address of the instruction.
	} fetch_req_t;

	// Decode result handed to the execute stage.
	typedef struct packed {
		logic                        valid;    // Request accepted this cycle.
		icache_types_pkg::index_t    index;    // Set of the request.
		icache_types_pkg::offset_t   offset;   // Byte offset in the line.
		icache_types_pkg::way_mask_t hit_way;  // Zero on a miss.
		icache_types_pkg::way_mask_t fill_way; // Victim, used only on a miss.
	} lookup_t;

endpackage

// File: hdl/icache_tag_lookup.sv
`include "icache_cfg.svh"

module icache_tag_lookup (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          hold,
	input  icache_pipe_pkg::fetch_req_t   req,
	output icache_pipe_pkg::lookup_t      lookup,
	output logic                          mem_rd,
	output icache_types_pkg::addr_t       mem_addr
);

	icache_types_pkg::tag_t tag_arr [`ICACHE_WAYS][`ICACHE_SETS]; // Tag store.
	logic [`ICACHE_SETS-1:0] valid_arr [`ICACHE_WAYS];            // Valid bit per line.
	icache_types_pkg::way_mask_t victim_q;                        // Rotating victim pointer.

	icache_types_pkg::tag_t req_tag;
	icache_types_pkg::index_t req_index;
	icache_types_pkg::offset_t req_offset;
	icache_types_pkg::way_mask_t hit_way;
	logic accept;
	logic fill;

	assign {req_tag, req_index, req_offset} = req.addr; // Address split.

	// A request is taken only when the pipe is not frozen.
	assign accept = req.valid && !hold && !rst;

	always_comb begin
		for (int w = 0; w < `ICACHE_WAYS; w++) begin
			hit_way[w] = valid_arr[w][req_index] && (tag_arr[w][req_index] == req_tag);
		end
	end

	assign fill = accept && (hit_way == '0); // Accepted miss.

	// Memory answers in the same cycle, so the read strobe is the miss itself.
	assign mem_rd   = fill;
	assign mem_addr = {req_tag, req_index, {`ICACHE_OFFSET_W{1'b0}}}; // Line aligned.

	always_comb begin
		lookup = '{
			valid:    accept,
			index:    req_index,
			offset:   req_offset,
			hit_way:  hit_way,
			fill_way: victim_q
		};
	end

	// Valid bits and victim pointer.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				valid_arr[w] <= '0;
			end
			victim_q <= {{(`ICACHE_WAYS-1){1'b0}}, 1'b1}; // Start at way 0.
		end else if (fill) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (victim_q[w]) begin
					valid_arr[w][req_index] <= 1'b1;
				end
			end
			victim_q <= {victim_q[`ICACHE_WAYS-2:0], victim_q[`ICACHE_WAYS-1]}; // Rotate left.
		end
	end

	// Tag write into the victim way.
	always_ff @(posedge clk) begin
		if (fill) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (victim_q[w]) begin
					tag_arr[w][req_index] <= req_tag;
				end
			end
		end
	end

endmodule

// File: hdl/icache_data_ways.sv
`include "icache_cfg.svh"

module icache_data_ways (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        hold,
	input  logic                        flush,
	input  icache_pipe_pkg::lookup_t    lookup,
	input  icache_types_pkg::line_t     mem_line,
	output icache_types_pkg::line_t     way_line0,
	output icache_types_pkg::line_t     way_line1,
	output icache_types_pkg::line_t     way_line2,
	output icache_types_pkg::line_t     way_line3,
	output icache_types_pkg::way_mask_t hit_way_q,
	output icache_types_pkg::line_t     fill_line_q,
	output icache_types_pkg::offset_t   offset_q,
	output logic                        ready
);

	icache_types_pkg::line_t line_arr [`ICACHE_WAYS][`ICACHE_SETS]; // Line store.
	icache_types_pkg::line_t rd_q [`ICACHE_WAYS];                   // Read of every way.
	logic fill;

	assign fill = lookup.valid && (lookup.hit_way == '0);

	// Fill the victim and read all ways at the request index.
	always_ff @(posedge clk) begin
		if (!hold) begin
			for (int w = 0; w < `ICACHE_WAYS; w++) begin
				if (fill && lookup.fill_way[w]) begin
					line_arr[w][lookup.index] <= mem_line;
				end
				rd_q[w] <= line_arr[w][lookup.index]; // Old data since a hit never needs the new line.
			end
		end
	end

	// Control of the output stage.
	always_ff @(posedge clk) begin
		if (rst) begin
			ready     <= 1'b0;
			hit_way_q <= '0;
		end else if (!hold) begin
			if (flush) begin
				ready     <= 1'b0; // Drop the result in flight.
				hit_way_q <= '0;
			end else begin
				ready <= lookup.valid;
				if (lookup.valid) begin
					hit_way_q <= lookup.hit_way;
				end
			end
		end
	end

	// Payload of the output stage.
	always_ff @(posedge clk) begin
		if (!hold) begin
			if (flush) begin
				fill_line_q <= '0;
			end else if (lookup.valid) begin
				fill_line_q <= mem_line; // Used when the request missed.
				offset_q    <= lookup.offset;
			end
		end
	end

	assign way_line0 = rd_q[0];
	assign way_line1 = rd_q[1];
	assign way_line2 = rd_q[2];
	assign way_line3 = rd_q[3];

endmodule

// File: hdl/icache_word_select.sv
module icache_word_select (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        hold,
	input  icache_types_pkg::line_t     way_line0,
	input  icache_types_pkg::line_t     way_line1,
	input  icache_types_pkg::line_t     way_line2,
	input  icache_types_pkg::line_t     way_line3,
	input  icache_types_pkg::way_mask_t hit_way_q,
	input  icache_types_pkg::line_t     fill_line_q,
	input  icache_types_pkg::offset_t   offset_q,
	output icache_types_pkg::word_t     inst
);

	icache_types_pkg::line_t sel_line; // Line of this response.
	logic [1:0] word_idx;

	always_comb begin
		case (hit_way_q)
			4'b0001: sel_line = way_line0;
			4'b0010: sel_line = way_line1;
			4'b0100: sel_line = way_line2;
			4'b1000: sel_line = way_line3;
			default: sel_line = fill_line_q; // A miss takes the line just fetched.
		endcase
	end

	// Execute freezes its registers under hold, so the selected line stays put.
	assign word_idx = offset_q[3:2]; // Word within the line.
	assign inst     = sel_line[word_idx*32 +: 32];

endmodule

// File: hdl/icache_top.sv
module icache_top (
	input  logic                        clk,
	input  logic                        rst,
	input  icache_pipe_pkg::fetch_req_t req,
	input  logic                        hold,
	input  logic                        flush,
	input  icache_types_pkg::line_t     mem_line,
	output logic                        mem_rd,
	output icache_types_pkg::addr_t     mem_addr,
	output logic                        ready,
	output icache_types_pkg::word_t     inst
);

	icache_pipe_pkg::lookup_t lookup;           // Decode to execute.
	icache_types_pkg::line_t way_line0;
	icache_types_pkg::line_t way_line1;
	icache_types_pkg::line_t way_line2;
	icache_types_pkg::line_t way_line3;
	icache_types_pkg::way_mask_t hit_way_q;
	icache_types_pkg::line_t fill_line_q;
	icache_types_pkg::offset_t offset_q;

	icache_tag_lookup u_tag_lookup (
		.clk      (clk),
		.rst      (rst),
		.hold     (hold),
		.req      (req),
		.lookup   (lookup),
		.mem_rd   (mem_rd),
		.mem_addr (mem_addr)
	);

	icache_data_ways u_data_ways (
		.clk         (clk),
		.rst         (rst),
		.hold        (hold),
		.flush       (flush),
		.lookup      (lookup),
		.mem_line    (mem_line),
		.way_line0   (way_line0),
		.way_line1   (way_line1),
		.way_line2   (way_line2),
		.way_line3   (way_line3),
		.hit_way_q   (hit_way_q),
		.fill_line_q (fill_line_q),
		.offset_q    (offset_q),
		.ready       (ready)
	);

	icache_word_select u_word_select (
		.clk         (clk),
		.rst         (rst),
		.hold        (hold),
		.way_line0   (way_line0),
		.way_line1   (way_line1),
		.way_line2   (way_line2),
		.way_line3   (way_line3),
		.hit_way_q   (hit_way_q),
		.fill_line_q (fill_line_q),
		.offset_q    (offset_q),
		.inst        (inst)
	);

endmodule

// File: verification/icache_tb.sv
module icache_tb;

	localparam string TEST_FILE = "verification/icache_tests.txt";

	// One line of the stimulus file.
	typedef struct packed {
		logic                    valid;
		logic                    hold;
		logic                    flush;
		icache_types_pkg::addr_t addr;
		logic                    miss; // Expected mem_rd when accepted.
		icache_types_pkg::word_t word; // Expected inst of the response.
	} test_vec_t;

	logic clk;
	logic rst;
	icache_pipe_pkg::fetch_req_t req;
	logic hold;
	logic flush;
	icache_types_pkg::line_t mem_line;
	logic mem_rd;
	icache_types_pkg::addr_t mem_addr;
	logic ready;
	icache_types_pkg::word_t inst;

	test_vec_t tests[$];
	logic load_ok;
	logic exp_ready;               // Model of ready after the last edge.
	icache_types_pkg::word_t exp_inst;
	int errors = 0;
	int checks = 0;
	int cycle_cnt = 0;
	int cycle_limit = 0;

	icache_top dut0 (
		.clk      (clk),
		.rst      (rst),
		.req      (req),
		.hold     (hold),
		.flush    (flush),
		.mem_line (mem_line),
		.mem_rd   (mem_rd),
		.mem_addr (mem_addr),
		.ready    (ready),
		.inst     (inst)
	);

	// Backing memory where each word is its own address with a fixed pattern.
	function automatic icache_types_pkg::word_t mem_word(input icache_types_pkg::addr_t addr);
		return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
	endfunction

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			mem_line[i*32 +: 32] = mem_word(mem_addr + 32'(i * 4)); // Zero latency memory.
		end
	end

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Checks: %0d, errors: %0d", checks, errors + 1);
			$display("Test failed");
			$finish;
		end
	end

	task automatic load_tests;
		int fd;
		int n;
		int v, h, f, m;
		logic [31:0] a, w;
		string line;
		test_vec_t t;
		begin
			fd = $fopen(TEST_FILE, "r");
			load_ok = (fd != 0);
			if (load_ok) begin
				while (!$feof(fd)) begin
					line = "";
					n = $fgets(line, fd);
					n = $sscanf(line, "%d %d %d %h %d %h", v, h, f, a, m, w);
					if (line.len() > 0 && line.getc(0) != "#" && n == 6) begin
						t.valid = (v != 0);
						t.hold  = (h != 0);
						t.flush = (f != 0);
						t.addr  = a;
						t.miss  = (m != 0);
						t.word  = w;
						tests.push_back(t);
					end
				end
				$fclose(fd);
			end
		end
	endtask

	// Expected words in the file must agree with the memory rule.
	task automatic check_test_words;
		foreach (tests[i]) begin
			if (tests[i].valid) begin
				checks++;
				assert (tests[i].word == mem_word(tests[i].addr)) else begin
					errors++;
					$display("Test line %0d expects a word that the memory cannot return", i);
				end
			end
		end
	endtask

	task automatic check_response;
		checks++;
		assert (ready === exp_ready) else begin
			errors++;
			$display("Mismatch ready: got %h, expected %h", ready, exp_ready);
		end
		if (exp_ready) begin
			checks++;
			assert (inst === exp_inst) else begin
				errors++;
				$display("Mismatch inst: got %h, expected %h", inst, exp_inst);
			end
		end
	endtask

	task automatic check_mem_rd(input test_vec_t t);
		logic exp_rd;
		icache_types_pkg::addr_t exp_addr;
		begin
			exp_rd   = t.valid && !t.hold && t.miss; // Only an accepted miss reads.
			exp_addr = {t.addr[31:4], 4'h0};         // Line aligned.
			checks++;
			assert (mem_rd === exp_rd) else begin
				errors++;
				$display("Mismatch mem_rd at %h: got %h, expected %h", t.addr, mem_rd, exp_rd);
			end
			if (exp_rd) begin
				checks++;
				assert (mem_addr === exp_addr) else begin
					errors++;
					$display("Mismatch mem_addr: got %h, expected %h", mem_addr, exp_addr);
				end
			end
		end
	endtask

	task automatic update_expected(input test_vec_t t);
		if (!t.hold) begin
			if (t.flush) begin
				exp_ready = 1'b0;
			end else begin
				exp_ready = t.valid;
				if (t.valid) begin
					exp_inst = t.word;
				end
			end
		end
	endtask

	initial begin
		rst       = 1'b1;
		req       = '0;
		hold      = 1'b0;
		flush     = 1'b0;
		exp_ready = 1'b0;
		exp_inst  = '0;
		load_tests();
		if (!load_ok) begin
			$display("Could not open the stimulus file %s", TEST_FILE);
			$display("Checks: %0d, errors: %0d", checks, errors + 1);
			$display("Test failed");
			$finish;
		end else begin
			cycle_limit = tests.size() + 20;
			check_test_words();
			repeat (5) @(posedge clk);
			rst <= 1'b0;
			@(negedge clk);
			check_response(); // Idle after reset.
			checks++;
			assert (mem_rd === 1'b0) else begin
				errors++;
				$display("Mismatch mem_rd after reset: got %h, expected 0", mem_rd);
			end
			foreach (tests[i]) begin
				@(posedge clk);
				req   <= '{valid: tests[i].valid, addr: tests[i].addr};
				hold  <= tests[i].hold;
				flush <= tests[i].flush;
				@(negedge clk);
				check_response(); // Result of the previous line.
				check_mem_rd(tests[i]);
				update_expected(tests[i]);
			end
			@(posedge clk);
			req   <= '0;
			hold  <= 1'b0;
			flush <= 1'b0;
			@(negedge clk);
			check_response();
			$display("Checks: %0d, errors: %0d", checks, errors);
			if (errors == 0) begin
				$display("Test passed");
			end else begin
				$display("Test failed");
			end
			$finish;
		end
	end

endmodule

// File: verification/icache_tests.txt
# valid hold flush address(hex) miss word(hex)
# word is the expected inst one cycle after the request is accepted
1 0 0 00001000 1 A5A51000
1 0 0 00001008 0 A5A51008
1 0 0 0000100C 0 A5A5100C
1 1 0 00002040 0 A5A52040
1 1 0 00002040 0 A5A52040
1 1 0 00002040 0 A5A52040
1 0 0 00002040 1 A5A52040
1 0 0 00010030 1 A5A40030
1 0 0 00020034 1 A5A70034
1 0 0 00030038 1 A5A60038
1 0 0 0004003C 1 A5A1003C
1 0 0 00050030 1 A5A00030
1 0 0 00020030 0 A5A70030
1 0 0 00010034 1 A5A40034
1 0 1 00006080 1 A5A56080
1 0 0 00006084 0 A5A56084
0 0 0 00000000 0 00000000
1 0 0 00001004 0 A5A51004
0 0 0 00000000 0 00000000

// File: tb.f
+incdir+hdl
hdl/icache_types_pkg.sv
hdl/icache_pipe_pkg.sv
hdl/icache_tag_lookup.sv
hdl/icache_data_ways.sv
hdl/icache_word_select.sv
hdl/icache_top.sv
verification/icache_tb.sv

// File: Makefile
TOP := icache_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
